/* rtl/poly_pkg.sv */
// Shared sizes, opcodes, status codes and the command word layout of the
// polynomial evaluator. Imported by every RTL block.
`default_nettype none

package poly_pkg;

    localparam int word_w = 16;                 // data path width.
    localparam int num_slots = 8;
    localparam int max_order = 15;
    localparam int slot_depth = 16;             // words per slot.
    localparam int store_depth = num_slots * slot_depth;

    localparam int slot_w = $clog2(num_slots);
    localparam int order_w = $clog2(max_order + 1);
    localparam int addr_w = $clog2(store_depth);
    localparam int count_w = 8;                 // evb block length.

    localparam logic [1:0] op_stp = 2'd0;
    localparam logic [1:0] op_evp = 2'd1;
    localparam logic [1:0] op_evb = 2'd2;
    localparam logic [1:0] op_rst = 2'd3;

    localparam logic [word_w-1:0] st_ok = 16'd0;
    localparam logic [word_w-1:0] st_empty_slot = 16'd1;
    localparam logic [word_w-1:0] st_bad_count = 16'd2;

    // opcode and slot sit in the same bits in both views
    typedef union packed {
        struct packed {
            logic [1:0] opcode;
            logic [slot_w-1:0] slot;
            logic [order_w-1:0] order;
            logic [6:0] pad;
        } ld;
        struct packed {
            logic [1:0] opcode;
            logic [slot_w-1:0] slot;
            logic [count_w-1:0] count;
            logic [2:0] pad;
        } ev;
    } cmd_word_u;

endpackage

`default_nettype wire

/* rtl/firing_ctrl.sv */
// Command fetch and firing control. Pops one command at a time, starts the
// matching engine and pushes its completion or results to the output FIFO.
`timescale 1ns/1ps
`default_nettype none

module firing_ctrl import poly_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  cmd_word_u           cmd_word,
    input  logic                cmd_empty,
    input  logic                out_full,
    input  logic                load_done,
    input  logic                res_valid,
    input  logic [word_w-1:0]   res_word,
    input  logic [word_w-1:0]   res_status,
    input  logic                eval_done,
    output logic                cmd_rd,
    output logic                load_start,
    output logic [slot_w-1:0]   load_slot,
    output logic [order_w-1:0]  load_order,
    output logic                eval_start,
    output logic [slot_w-1:0]   eval_slot,
    output logic [count_w-1:0]  eval_count,
    output logic                clr_all,
    output logic                res_taken,
    output logic                out_wr,
    output logic [word_w-1:0]   result_word,
    output logic [word_w-1:0]   status_word
);

    localparam logic [2:0] s_idle = 3'd0;
    localparam logic [2:0] s_stp_go = 3'd1;
    localparam logic [2:0] s_stp_wait = 3'd2;
    localparam logic [2:0] s_ev_go = 3'd3;
    localparam logic [2:0] s_ev_wait = 3'd4;
    localparam logic [2:0] s_rst = 3'd5;
    localparam logic [2:0] s_out = 3'd6;

    logic [2:0] state;
    cmd_word_u cmd_q;

    // fetch happens in the idle state itself, never in reset.
    assign cmd_rd = rst && (state == s_idle) && !cmd_empty;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= s_idle;
        else
        begin
            case (state)
                s_idle:
                    if (!cmd_empty)
                    begin
                        case (cmd_word.ld.opcode)
                            op_stp:         state <= s_stp_go;
                            op_evp, op_evb: state <= s_ev_go;
                            default:        state <= s_rst;
                        endcase
                    end
                s_stp_go:   state <= s_stp_wait;
                s_stp_wait: if (load_done) state <= s_out;
                s_out:      if (!out_full) state <= s_idle;
                s_ev_go:    state <= s_ev_wait;
                s_ev_wait:  if (eval_done) state <= s_idle;   // after last result.
                default:    state <= s_idle;                  // s_rst is one cycle.
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_rd)
            cmd_q <= cmd_word;
    end

    // stp reads the load view, evp/evb the evaluate view.
    assign load_start = (state == s_stp_go);
    assign load_slot = cmd_q.ld.slot;
    assign load_order = cmd_q.ld.order;

    assign eval_start = (state == s_ev_go);
    assign eval_slot = cmd_q.ev.slot;
    assign eval_count = (cmd_q.ev.opcode == op_evb) ? cmd_q.ev.count : count_w'(1);

    assign clr_all = (state == s_rst);

    assign res_taken = (state == s_ev_wait) && res_valid && !out_full;
    assign out_wr = res_taken || ((state == s_out) && !out_full);
    assign result_word = (state == s_ev_wait) ? res_word : '0;     // stp reports zero.
    assign status_word = (state == s_ev_wait) ? res_status : st_ok;

endmodule

`default_nettype wire

/* rtl/coef_loader.sv */
// STP engine. Pops order+1 coefficients, highest power first, into one slot
// of the coefficient store, then marks the slot loaded.
`timescale 1ns/1ps
`default_nettype none

module coef_loader import poly_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                load_start,
    input  logic [slot_w-1:0]   load_slot,
    input  logic [order_w-1:0]  load_order,
    input  logic [word_w-1:0]   data_word,
    input  logic                data_empty,
    input  logic                ld_gnt,
    output logic                ld_req,
    output logic                ld_we,
    output logic [addr_w-1:0]   ld_addr,
    output logic [word_w-1:0]   ld_wdata,
    output logic                ld_pop,
    output logic                ld_set_order,
    output logic [order_w-1:0]  ld_order,
    output logic                load_done
);

    logic busy;
    logic act;
    logic [order_w-1:0] idx;
    logic [slot_w-1:0] slot_q;
    logic [order_w-1:0] order_q;

    assign ld_req = busy;
    assign act = busy && ld_gnt && !data_empty;   // one coefficient per cycle.

    assign ld_we = act;
    assign ld_pop = act;
    assign ld_addr = {slot_q, idx};               // slot * 16 + power.
    assign ld_wdata = data_word;
    assign ld_set_order = act && (idx == '0);
    assign ld_order = order_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy <= 1'b0;
            idx <= '0;
            load_done <= 1'b0;
        end
        else
        begin
            load_done <= ld_set_order;
            if (load_start)
            begin
                busy <= 1'b1;
                idx <= load_order;
            end
            else if (act)
            begin
                idx <= idx - 1'b1;
                if (idx == '0)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_start)
        begin
            slot_q <= load_slot;
            order_q <= load_order;
        end
    end

endmodule

`default_nettype wire

/* rtl/horner_eval.sv */
// EVP/EVB engine. Evaluates one loaded slot at count x values by Horner's
// rule, modulo 2^16, and hands each result to the controller.
`timescale 1ns/1ps
`default_nettype none

module horner_eval import poly_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                eval_start,
    input  logic [slot_w-1:0]   eval_slot,
    input  logic [count_w-1:0]  eval_count,
    input  logic [word_w-1:0]   data_word,
    input  logic                data_empty,
    input  logic                ev_gnt,
    input  logic [word_w-1:0]   ev_rdata,
    input  logic [order_w-1:0]  ev_order,
    input  logic                ev_loaded,
    input  logic                res_taken,
    output logic                ev_req,
    output logic [addr_w-1:0]   ev_addr,
    output logic                ev_pop,
    output logic                res_valid,
    output logic [word_w-1:0]   res_word,
    output logic [word_w-1:0]   res_status,
    output logic                eval_done
);

    localparam logic [1:0] s_idle = 2'd0;
    localparam logic [1:0] s_pop = 2'd1;
    localparam logic [1:0] s_step = 2'd2;
    localparam logic [1:0] s_res = 2'd3;

    logic [1:0] state;
    logic [count_w-1:0] left;          // x values still to go.
    logic [order_w-1:0] rem;           // power of the coefficient in ev_rdata.
    logic [order_w-1:0] order_q;
    logic [word_w-1:0] x_q;
    logic [word_w-1:0] acc;
    logic [word_w-1:0] status_q;
    logic start_ok;
    logic pop_go;
    logic step_go;

    assign start_ok = ev_loaded && (eval_count != '0);
    assign pop_go = (state == s_pop) && ev_gnt && !data_empty;
    assign step_go = (state == s_step) && ev_gnt;

    assign ev_req = (state == s_pop) || (state == s_step);
    assign ev_pop = pop_go;
    // pop cycle fetches the top coefficient, each step prefetches the next.
    assign ev_addr = {eval_slot, (state == s_pop) ? order_q : rem - 1'b1};

    assign res_valid = (state == s_res);
    assign res_word = acc;
    assign res_status = status_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= s_idle;
            left <= '0;
            rem <= '0;
            eval_done <= 1'b0;
        end
        else
        begin
            eval_done <= 1'b0;
            case (state)
                s_idle:
                    if (eval_start)
                    begin
                        left <= start_ok ? eval_count : count_w'(1);
                        state <= start_ok ? s_pop : s_res;   // errors skip the pop.
                    end
                s_pop:
                    if (pop_go)
                    begin
                        rem <= order_q;
                        state <= s_step;
                    end
                s_step:
                    if (step_go)
                    begin
                        rem <= rem - 1'b1;
                        if (rem == '0)
                            state <= s_res;
                    end
                default:
                    if (res_taken)
                    begin
                        left <= left - 1'b1;
                        eval_done <= (left == count_w'(1));
                        state <= (left == count_w'(1)) ? s_idle : s_pop;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == s_idle) && eval_start)
        begin
            order_q <= ev_order;
            acc <= '0;
            if (!ev_loaded)
                status_q <= st_empty_slot;
            else
                status_q <= start_ok ? st_ok : st_bad_count;
        end
        if (pop_go)
        begin
            x_q <= data_word;
            acc <= '0;                 // first step then yields the top coefficient.
        end
        else if (step_go)
            acc <= acc * x_q + ev_rdata;
    end

endmodule

`default_nettype wire

/* rtl/store_arbiter.sv */
// Coefficient store shared by the loader and the evaluator, with the order
// table and loaded flags. Grants the store and the data FIFO pop.
`timescale 1ns/1ps
`default_nettype none

module store_arbiter import poly_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                clr_all,
    input  logic                ld_req,
    input  logic                ld_we,
    input  logic [addr_w-1:0]   ld_addr,
    input  logic [word_w-1:0]   ld_wdata,
    input  logic                ld_pop,
    input  logic                ld_set_order,
    input  logic [order_w-1:0]  ld_order,
    input  logic                ev_req,
    input  logic [addr_w-1:0]   ev_addr,
    input  logic                ev_pop,
    input  logic [slot_w-1:0]   eval_slot,
    output logic                ld_gnt,
    output logic                ev_gnt,
    output logic [word_w-1:0]   ev_rdata,
    output logic [order_w-1:0]  ev_order,
    output logic                ev_loaded,
    output logic                data_rd
);

    logic [word_w-1:0] mem [store_depth];
    logic [order_w-1:0] order_tab [num_slots];
    logic [num_slots-1:0] loaded;
    logic [slot_w-1:0] ld_slot;

    // loader first.
    assign ld_gnt = ld_req;
    assign ev_gnt = ev_req && !ld_req;

    assign ld_slot = ld_addr[addr_w-1 -: slot_w];
    assign data_rd = (ld_gnt && ld_pop) || (ev_gnt && ev_pop);

    always_ff @(posedge clk)
    begin
        if (ld_gnt && ld_we)
            mem[ld_addr] <= ld_wdata;
        if (ev_gnt)
            ev_rdata <= mem[ev_addr];  // held while the evaluator is not granted.
        if (ld_gnt && ld_set_order)
            order_tab[ld_slot] <= ld_order;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            loaded <= '0;
        else if (clr_all)
            loaded <= '0;
        else if (ld_gnt && ld_set_order)
            loaded[ld_slot] <= 1'b1;
    end

    assign ev_order = order_tab[eval_slot];
    assign ev_loaded = loaded[eval_slot];

endmodule

`default_nettype wire

/* rtl/poly_eval_top.sv */
// Polynomial evaluation actor. Connects the controller, both engines and the
// shared store to the command, data and output FIFO ports.
`timescale 1ns/1ps
`default_nettype none

module poly_eval_top import poly_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  cmd_word_u           cmd_word,
    input  logic                cmd_empty,
    output logic                cmd_rd,
    input  logic [word_w-1:0]   data_word,
    input  logic                data_empty,
    output logic                data_rd,
    output logic [word_w-1:0]   result_word,
    output logic [word_w-1:0]   status_word,
    input  logic                out_full,
    output logic                out_wr
);

    logic load_start;
    logic load_done;
    logic [slot_w-1:0] load_slot;
    logic [order_w-1:0] load_order;
    logic eval_start;
    logic eval_done;
    logic [slot_w-1:0] eval_slot;
    logic [count_w-1:0] eval_count;
    logic res_valid;
    logic res_taken;
    logic [word_w-1:0] res_word;
    logic [word_w-1:0] res_status;
    logic clr_all;

    logic ld_req;
    logic ld_gnt;
    logic ld_we;
    logic ld_pop;
    logic ld_set_order;
    logic [addr_w-1:0] ld_addr;
    logic [word_w-1:0] ld_wdata;
    logic [order_w-1:0] ld_order;
    logic ev_req;
    logic ev_gnt;
    logic ev_pop;
    logic ev_loaded;
    logic [addr_w-1:0] ev_addr;
    logic [word_w-1:0] ev_rdata;
    logic [order_w-1:0] ev_order;

    // port names match the nets one to one.
    firing_ctrl u_firing_ctrl (.*);

    coef_loader u_coef_loader (.*);

    horner_eval u_horner_eval (.*);

    store_arbiter u_store_arbiter (.*);

endmodule

`default_nettype wire

/* tests/poly_eval_chk.sv */
// Protocol checks on the evaluator's FIFO strobes, bound into every
// instance of the top level by the bind at the end of this file.
`timescale 1ns/1ps
`default_nettype none

module poly_eval_chk
(
    input  logic clk,
    input  logic rst,
    input  logic cmd_empty,
    input  logic cmd_rd,
    input  logic data_empty,
    input  logic data_rd,
    input  logic out_full,
    input  logic out_wr
);

    int fails = 0;                      // assertion failures so far.

    a_out_wr: assert property (@(posedge clk) disable iff (!rst) out_wr |-> !out_full)
        else
        begin
            fails++;
            $error("out_wr raised while the output FIFO is full");
        end

    a_cmd_rd: assert property (@(posedge clk) disable iff (!rst) cmd_rd |-> !cmd_empty)
        else
        begin
            fails++;
            $error("cmd_rd raised while the command FIFO is empty");
        end

    a_data_rd: assert property (@(posedge clk) disable iff (!rst) data_rd |-> !data_empty)
        else
        begin
            fails++;
            $error("data_rd raised while the data FIFO is empty");
        end

    // all strobes stay quiet in reset.
    a_reset_quiet: assert property (@(posedge clk) !rst |-> !(cmd_rd || data_rd || out_wr))
        else
        begin
            fails++;
            $error("strobe raised during reset");
        end

endmodule

bind poly_eval_top poly_eval_chk u_poly_eval_chk
(
    .clk        (clk),
    .rst        (rst),
    .cmd_empty  (cmd_empty),
    .cmd_rd     (cmd_rd),
    .data_empty (data_empty),
    .data_rd    (data_rd),
    .out_full   (out_full),
    .out_wr     (out_wr)
);

`default_nettype wire

/* tests/tb_poly_eval.sv */
// Directed testbench for the polynomial evaluator. Queue models stand in for
// the three FIFOs and a Horner model gives every expected output word.
`timescale 1ns/1ps
`default_nettype none

module tb_poly_eval import poly_pkg::*;
();

    localparam int timeout_cycles = 20000;     // all tests need a few thousand.

    logic clk = 1'b0;
    logic rst = 1'b0;
    cmd_word_u cmd_word = '0;
    logic cmd_empty = 1'b1;
    logic cmd_rd;
    logic [word_w-1:0] data_word = '0;
    logic data_empty = 1'b1;
    logic data_rd;
    logic [word_w-1:0] result_word;
    logic [word_w-1:0] status_word;
    logic out_full = 1'b0;
    logic out_wr;

    logic [word_w-1:0] cmd_q [$];
    logic [word_w-1:0] data_q [$];
    logic [word_w-1:0] got_res [$];
    logic [word_w-1:0] got_st [$];
    logic [word_w-1:0] exp_res [$];
    logic [word_w-1:0] exp_st [$];
    bit exp_skip [$];                          // error results carry no value.

    logic [word_w-1:0] coef [num_slots][slot_depth];
    int order_tab [num_slots];
    bit loaded [num_slots];
    integer seed = 32'h2aba;
    integer stall_seed = 32'h2aba;
    logic [word_w-1:0] stall_rnd;
    bit stall_out = 1'b0;
    int errors = 0;
    int assert_fails = 0;
    int checks = 0;
    int cycles = 0;
    string test_name;

    poly_eval_top u_poly_eval_top (.*);

    always #2 clk = ~clk;

    // fifo models, first word falls through.
    always @(posedge clk)
    begin
        if (cmd_rd && cmd_q.size() > 0)
            void'(cmd_q.pop_front());
        if (data_rd && data_q.size() > 0)
            void'(data_q.pop_front());
        if (out_wr)
        begin
            got_res.push_back(result_word);
            got_st.push_back(status_word);
        end
        stall_rnd = 16'($random(stall_seed));
        cmd_empty <= (cmd_q.size() == 0);
        cmd_word <= (cmd_q.size() > 0) ? cmd_q[0] : '0;
        data_empty <= (data_q.size() == 0);
        data_word <= (data_q.size() > 0) ? data_q[0] : '0;
        out_full <= stall_out && stall_rnd[0];
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, outputs still missing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [word_w-1:0] rand_word();
        return 16'($random(seed));
    endfunction

    function automatic logic [word_w-1:0] ev_cmd(input logic [1:0] op,
                                                 input logic [slot_w-1:0] slot,
                                                 input logic [count_w-1:0] count);
        return {op, slot, count, 3'b000};
    endfunction

    // top coefficient first, then multiply by x and add the next one down.
    function automatic logic [word_w-1:0] model_eval(input logic [slot_w-1:0] slot,
                                                     input logic [word_w-1:0] x);
        logic [word_w-1:0] acc;
        acc = coef[slot][4'(order_tab[slot])];
        for (int p = order_tab[slot] - 1; p >= 0; p--)
            acc = acc * x + coef[slot][4'(p)];
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [word_w-1:0] exp,
                               input logic [word_w-1:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("** Error [%s]: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic expect_output(input logic [word_w-1:0] res, input logic [word_w-1:0] st,
                                 input bit skip_res);
        exp_res.push_back(res);
        exp_st.push_back(st);
        exp_skip.push_back(skip_res);
    endtask

    task automatic load_poly(input logic [slot_w-1:0] slot, input int order);
        logic [word_w-1:0] c;
        cmd_q.push_back({op_stp, slot, 4'(order), 7'd0});
        order_tab[slot] = order;
        for (int p = order; p >= 0; p--)
        begin
            c = rand_word();
            coef[slot][4'(p)] = c;
            data_q.push_back(c);                // highest power goes first.
        end
        loaded[slot] = 1'b1;
        expect_output('0, st_ok, 1'b0);
    endtask

    task automatic eval_point(input logic [slot_w-1:0] slot, input logic [word_w-1:0] x);
        cmd_q.push_back(ev_cmd(op_evp, slot, 8'd0));
        data_q.push_back(x);
        if (loaded[slot])
            expect_output(model_eval(slot, x), st_ok, 1'b0);
        else
            expect_output('0, st_empty_slot, 1'b1);
    endtask

    task automatic eval_block(input logic [slot_w-1:0] slot, input int count,
                              input int gap_max);
        logic [word_w-1:0] x;
        cmd_q.push_back(ev_cmd(op_evb, slot, 8'(count)));
        if (count == 0)
            expect_output('0, st_bad_count, 1'b1);
        for (int i = 0; i < count; i++)
        begin
            x = rand_word();
            data_q.push_back(x);
            expect_output(model_eval(slot, x), st_ok, 1'b0);
            if (gap_max > 0)
                repeat (int'(rand_word()) % (gap_max + 1)) @(posedge clk);
        end
    endtask

    task automatic collect_outputs();
        logic [word_w-1:0] res;
        logic [word_w-1:0] st;
        logic [word_w-1:0] want;
        bit skip;
        while (got_res.size() < exp_res.size())
            @(posedge clk);
        repeat (30) @(posedge clk);             // room for a stray extra word.
        if (got_res.size() != exp_res.size())
        begin
            errors++;
            $display("%s: %0d output words arrived where %0d were expected",
                     test_name, got_res.size(), exp_res.size());
        end
        while (exp_res.size() > 0 && got_res.size() > 0)
        begin
            res = got_res.pop_front();
            st = got_st.pop_front();
            want = exp_res.pop_front();
            skip = exp_skip.pop_front();
            check_value({test_name, " status"}, exp_st.pop_front(), st);
            if (!skip)
                check_value({test_name, " result"}, want, res);
        end
        exp_res.delete();
        exp_st.delete();
        exp_skip.delete();
        got_res.delete();
        got_st.delete();
    endtask

    task automatic test_load_eval();
        test_name = "load_eval";
        load_poly(3'd1, 3);
        eval_point(3'd1, rand_word());
        collect_outputs();
    endtask

    task automatic test_block();
        test_name = "block";
        eval_block(3'd1, 10, 0);
        collect_outputs();
    endtask

    task automatic test_errors();
        logic [word_w-1:0] x;
        test_name = "errors";
        x = rand_word();
        eval_point(3'd5, x);                    // slot 5 was never loaded.
        collect_outputs();
        if (data_q.size() != 1)
        begin
            errors++;
            $display("%s: the error firing took an x value from the data FIFO", test_name);
        end
        // the x left behind now feeds slot 1.
        cmd_q.push_back(ev_cmd(op_evp, 3'd1, 8'd0));
        expect_output(model_eval(3'd1, x), st_ok, 1'b0);
        eval_block(3'd1, 0, 0);
        collect_outputs();
        cmd_q.push_back({op_rst, 3'd0, 11'd0});
        loaded = '{default: 1'b0};
        eval_point(3'd1, rand_word());
        collect_outputs();
        if (data_q.size() != 1)
        begin
            errors++;
            $display("%s: evaluation after reset took an x value", test_name);
        end
        data_q.delete();
    endtask

    task automatic test_slots();
        logic [slot_w-1:0] slots [4] = '{3'd0, 3'd7, 3'd3, 3'd2};
        test_name = "slots";
        load_poly(3'd0, 0);
        load_poly(3'd7, 15);
        load_poly(3'd3, 5);
        load_poly(3'd2, 1);
        for (int i = 0; i < 12; i++)
            eval_point(slots[2'(i)], rand_word());
        eval_block(3'd7, 3, 0);
        collect_outputs();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        stall_out = 1'b1;
        load_poly(3'd4, 2);
        eval_block(3'd4, 12, 6);                // x values trickle in.
        eval_point(3'd7, rand_word());
        eval_block(3'd0, 5, 3);
        collect_outputs();
        stall_out = 1'b0;
    endtask

    initial
    begin
        loaded = '{default: 1'b0};
        fork
            test_load_eval();                   // its words wait in the fifos during reset.
            begin
                repeat (10) @(posedge clk);
                rst <= 1'b1;
            end
        join
        test_block();
        test_errors();
        test_slots();
        test_backpressure();
        assert_fails = u_poly_eval_top.u_poly_eval_chk.fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/poly_pkg.sv
rtl/firing_ctrl.sv
rtl/coef_loader.sv
rtl/horner_eval.sv
rtl/store_arbiter.sv
rtl/poly_eval_top.sv
tests/poly_eval_chk.sv
tests/tb_poly_eval.sv

/* Makefile */
SRCS := $(shell cat sim.f)

obj_dir/Vtb_poly_eval: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_poly_eval -f sim.f

run: obj_dir/Vtb_poly_eval
	@out=$$(./obj_dir/Vtb_poly_eval); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: run clean
